//--- verilog/mask_unit_params.svh
`ifndef MASK_UNIT_PARAMS_SVH
`define MASK_UNIT_PARAMS_SVH

`define VLEN             128
`define VLENB            16
`define XLEN             32
`define VL_WIDTH         8
`define ROB_DEPTH_WIDTH  3
`define UOP_INDEX_WIDTH  3
`define FUNCT6_WIDTH     6
`define FUNCT3_WIDTH     3
`define VS1_OP_WIDTH     5

// element width codes
`define EEW8             2'b00
`define EEW16            2'b01
`define EEW32            2'b10

`define OPMVV            3'b010

// mask logical funct6
`define VMANDN           6'b011000
`define VMAND            6'b011001
`define VMOR             6'b011010
`define VMXOR            6'b011011
`define VMORN            6'b011100
`define VMNAND           6'b011101
`define VMNOR            6'b011110
`define VMXNOR           6'b011111
`define VWXUNARY0        6'b010000
`define VMUNARY0         6'b010100

// vs1 field opcodes
`define VCPOP            5'b10000
`define VFIRST           5'b10001
`define VMSBF            5'b00001
`define VMSOF            5'b00010
`define VMSIF            5'b00011
`define VIOTA            5'b10000
`define VID              5'b10001

// internal operation codes
`define MOP_LOGIC        4'd0
`define MOP_CPOP         4'd1
`define MOP_FIRST        4'd2
`define MOP_SBF          4'd3
`define MOP_SOF          4'd4
`define MOP_SIF          4'd5
`define MOP_IOTA         4'd6
`define MOP_ID           4'd7

`endif

//--- verilog/mask_unit_pkg.sv
`include "mask_unit_params.svh"

package mask_unit_pkg;

  // one full vector register
  typedef logic [`VLEN-1:0]            vreg_t;

  // vl and vstart share a width
  typedef logic [`VL_WIDTH-1:0]        vl_t;

  typedef logic [`ROB_DEPTH_WIDTH-1:0] rob_entry_t;

  typedef logic [`FUNCT6_WIDTH-1:0]    funct6_t;

  typedef logic [`FUNCT3_WIDTH-1:0]    funct3_t;

  // vs1 register field used as an opcode
  typedef logic [`VS1_OP_WIDTH-1:0]    vs1_op_t;

  typedef logic [`UOP_INDEX_WIDTH-1:0] uop_index_t;

  typedef logic [1:0]                  eew_t;

  typedef logic [3:0]                  mask_op_t;

endpackage

//--- verilog/mask_uop_decode.sv
`include "mask_unit_params.svh"

module mask_uop_decode (
  input  logic                     uop_valid,
  input  mask_unit_pkg::funct3_t   funct3,
  input  mask_unit_pkg::funct6_t   funct6,
  input  mask_unit_pkg::vs1_op_t   vs1_opcode,
  input  logic                     vm,
  input  logic                     v0_valid,
  input  logic                     vd_valid,
  input  logic                     vs1_valid,
  input  logic                     vs2_valid,
  output logic                     issue,
  output mask_unit_pkg::mask_op_t  op
);

  logic supported;
  logic ready;
  logic logic_ok;
  logic unary_ok;
  logic set_ok;

  // operand rules per class
  assign logic_ok = vs1_valid && vs2_valid && vd_valid && vm;
  assign unary_ok = !vs1_valid && vs2_valid && (vm || v0_valid);
  assign set_ok   = !vs1_valid && vs2_valid && (vm || (vd_valid && v0_valid));

  always_comb begin
    supported = 1'b0;
    ready     = 1'b0;
    op        = `MOP_LOGIC;
    if (funct3 == `OPMVV) begin
      case (funct6)
        `VMANDN, `VMAND, `VMOR, `VMXOR, `VMORN, `VMNAND, `VMNOR, `VMXNOR: begin
          supported = 1'b1;
          ready     = logic_ok;
        end
        `VWXUNARY0: begin
          ready = unary_ok;
          case (vs1_opcode)
            `VCPOP: begin
              supported = 1'b1;
              op        = `MOP_CPOP;
            end
            `VFIRST: begin
              supported = 1'b1;
              op        = `MOP_FIRST;
            end
            default: supported = 1'b0;
          endcase
        end
        `VMUNARY0: begin
          ready = set_ok;
          case (vs1_opcode)
            `VMSBF: begin
              supported = 1'b1;
              op        = `MOP_SBF;
            end
            `VMSOF: begin
              supported = 1'b1;
              op        = `MOP_SOF;
            end
            `VMSIF: begin
              supported = 1'b1;
              op        = `MOP_SIF;
            end
            `VIOTA: begin
              supported = 1'b1;
              ready     = unary_ok;
              op        = `MOP_IOTA;
            end
            // vid reads no operand
            `VID: begin
              supported = 1'b1;
              ready     = 1'b1;
              op        = `MOP_ID;
            end
            default: supported = 1'b0;
          endcase
        end
        default: supported = 1'b0;
      endcase
    end
  end

  assign issue = uop_valid && supported && ready;

endmodule

//--- verilog/mask_logic_unit.sv
`include "mask_unit_params.svh"

module mask_logic_unit (
  input  mask_unit_pkg::funct6_t  funct6,
  input  mask_unit_pkg::vl_t      vstart,
  input  mask_unit_pkg::vreg_t    vs1_data,
  input  mask_unit_pkg::vreg_t    vs2_data,
  input  mask_unit_pkg::vreg_t    vd_data,
  output mask_unit_pkg::vreg_t    logic_result
);

  mask_unit_pkg::vreg_t raw;

  // vs2 is the left operand
  always_comb begin
    case (funct6)
      `VMANDN: raw = vs2_data & ~vs1_data;
      `VMAND:  raw = vs2_data & vs1_data;
      `VMOR:   raw = vs2_data | vs1_data;
      `VMXOR:  raw = vs2_data ^ vs1_data;
      `VMORN:  raw = vs2_data | ~vs1_data;
      `VMNAND: raw = ~(vs2_data & vs1_data);
      `VMNOR:  raw = ~(vs2_data | vs1_data);
      `VMXNOR: raw = ~(vs2_data ^ vs1_data);
      default: raw = '0;
    endcase
  end

  // prestart bits keep vd
  always_comb begin
    for (int j = 0; j < `VLEN; j++) begin
      logic_result[j] = (j < int'(vstart)) ? vd_data[j] : raw[j];
    end
  end

endmodule

//--- verilog/mask_scan_unit.sv
`include "mask_unit_params.svh"

module mask_scan_unit (
  input  mask_unit_pkg::mask_op_t  op,
  input  logic                     vm,
  input  mask_unit_pkg::vl_t       vl,
  input  mask_unit_pkg::vreg_t     v0_data,
  input  mask_unit_pkg::vreg_t     vs2_data,
  input  mask_unit_pkg::vreg_t     vd_data,
  output mask_unit_pkg::vreg_t     scan_result
);

  mask_unit_pkg::vreg_t       tail_mask;
  mask_unit_pkg::vreg_t       src;
  mask_unit_pkg::vreg_t       first1;
  mask_unit_pkg::vreg_t       set_mask;
  mask_unit_pkg::vreg_t       keep_vd;
  mask_unit_pkg::vreg_t       merged;
  logic [$clog2(`VLEN)-1:0]   first_idx;
  logic [`XLEN-1:0]           cpop;

  always_comb begin
    for (int j = 0; j < `VLEN; j++) begin
      tail_mask[j] = (j < int'(vl));
    end
  end

  assign src    = vs2_data & tail_mask & (vm ? {`VLEN{1'b1}} : v0_data);
  // isolate lowest set bit
  assign first1 = src & (~src + 1'b1);

  always_comb begin
    case (op)
      `MOP_SBF: set_mask = first1 - 1'b1;
      `MOP_SIF: set_mask = (first1 - 1'b1) | first1;
      default:  set_mask = first1;
    endcase
    if (src == '0) begin
      set_mask = {`VLEN{1'b1}};
    end
  end

  // inactive body elements keep vd when masked
  assign keep_vd = vm ? '0 : (tail_mask & ~v0_data);
  assign merged  = (keep_vd & vd_data) | (~keep_vd & set_mask);

  always_comb begin
    first_idx = '0;
    for (int i = `VLEN - 1; i >= 0; i--) begin
      if (src[i]) begin
        first_idx = i[$clog2(`VLEN)-1:0];
      end
    end
  end

  always_comb begin
    cpop = '0;
    for (int i = 0; i < `VLEN; i++) begin
      cpop = cpop + `XLEN'(src[i]);
    end
  end

  always_comb begin
    case (op)
      `MOP_CPOP:  scan_result = `VLEN'(cpop);
      `MOP_FIRST: scan_result = (src == '0) ? {`VLEN{1'b1}} : `VLEN'(first_idx);
      `MOP_SBF, `MOP_SOF, `MOP_SIF: scan_result = merged;
      default:    scan_result = '0;
    endcase
  end

endmodule

//--- verilog/mask_index_unit.sv
`include "mask_unit_params.svh"

module mask_index_unit (
  input  mask_unit_pkg::mask_op_t    op,
  input  logic                       vm,
  input  mask_unit_pkg::vreg_t       v0_data,
  input  mask_unit_pkg::vreg_t       vs2_data,
  input  mask_unit_pkg::uop_index_t  uop_index,
  input  mask_unit_pkg::eew_t        vd_eew,
  output mask_unit_pkg::vreg_t       index_result
);

  localparam int CNT_W = $clog2(`VLEN);

  mask_unit_pkg::vreg_t  src;
  logic [CNT_W-1:0]      seg_a [`VLEN/4];
  logic [CNT_W-1:0]      seg_b [`VLEN/4];
  logic [CNT_W-1:0]      seg_c [`VLEN/2];
  logic [CNT_W-1:0]      total_a;
  logic [CNT_W-1:0]      total_b;
  logic [CNT_W-1:0]      iota [`VLEN];

  assign src = vm ? vs2_data : (vs2_data & v0_data);

  // three independent carry chains, stitched afterwards
  always_comb begin
    seg_a[0] = '0;
    seg_b[0] = '0;
    seg_c[0] = '0;
    for (int k = 1; k < `VLEN/4; k++) begin
      seg_a[k] = seg_a[k-1] + CNT_W'(src[k-1]);
      seg_b[k] = seg_b[k-1] + CNT_W'(src[`VLEN/4+k-1]);
    end
    for (int k = 1; k < `VLEN/2; k++) begin
      seg_c[k] = seg_c[k-1] + CNT_W'(src[`VLEN/2+k-1]);
    end
  end

  assign total_a = seg_a[`VLEN/4-1] + CNT_W'(src[`VLEN/4-1]);
  assign total_b = seg_b[`VLEN/4-1] + CNT_W'(src[`VLEN/2-1]);

  always_comb begin
    for (int j = 0; j < `VLEN/4; j++) begin
      iota[j]          = seg_a[j];
      iota[`VLEN/4+j]  = seg_b[j] + total_a;
    end
    for (int j = 0; j < `VLEN/2; j++) begin
      iota[`VLEN/2+j] = seg_c[j] + total_a + total_b;
    end
  end

  always_comb begin
    logic [CNT_W-1:0] g;
    logic [CNT_W-1:0] elem;
    index_result = '0;
    g            = '0;
    elem         = '0;
    if (op == `MOP_IOTA || op == `MOP_ID) begin
      case (vd_eew)
        `EEW8: for (int i = 0; i < `VLENB; i++) begin
          g    = {uop_index, i[3:0]};
          elem = (op == `MOP_IOTA) ? iota[g] : g;
          index_result[i*8 +: 8] = 8'(elem);
        end
        `EEW16: for (int i = 0; i < `VLEN/16; i++) begin
          g    = {1'b0, uop_index, i[2:0]};
          elem = (op == `MOP_IOTA) ? iota[g] : g;
          index_result[i*16 +: 16] = 16'(elem);
        end
        `EEW32: for (int i = 0; i < `VLEN/32; i++) begin
          g    = {2'b00, uop_index, i[1:0]};
          elem = (op == `MOP_IOTA) ? iota[g] : g;
          index_result[i*32 +: 32] = 32'(elem);
        end
        default: index_result = '0;
      endcase
    end
  end

endmodule

//--- verilog/mask_result_reg.sv
`include "mask_unit_params.svh"

module mask_result_reg (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       issue,
  input  mask_unit_pkg::mask_op_t    op,
  input  mask_unit_pkg::rob_entry_t  rob_entry,
  input  mask_unit_pkg::vreg_t       logic_result,
  input  mask_unit_pkg::vreg_t       scan_result,
  input  mask_unit_pkg::vreg_t       index_result,
  output logic                       result_valid,
  output mask_unit_pkg::rob_entry_t  result_rob_entry,
  output mask_unit_pkg::vreg_t       result_data,
  output logic                       ignore_vta,
  output logic                       ignore_vma
);

  mask_unit_pkg::vreg_t sel_data;
  logic                 set_op;
  logic                 vta;
  logic                 vma;

  always_comb begin
    case (op)
      `MOP_LOGIC:               sel_data = logic_result;
      `MOP_IOTA, `MOP_ID:       sel_data = index_result;
      default:                  sel_data = scan_result;
    endcase
  end

  // mask-producing ops own their tail
  assign set_op = (op == `MOP_SBF) || (op == `MOP_SOF) || (op == `MOP_SIF);
  assign vta    = (op == `MOP_LOGIC) || set_op;
  assign vma    = set_op;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result_valid     <= 1'b0;
      ignore_vta       <= 1'b0;
      ignore_vma       <= 1'b0;
      result_rob_entry <= '0;
      result_data      <= '0;
    end else begin
      result_valid <= issue;
      ignore_vta   <= issue && vta;
      ignore_vma   <= issue && vma;
      if (issue) begin
        result_rob_entry <= rob_entry;
        result_data      <= sel_data;
      end
    end
  end

endmodule

//--- verilog/mask_unit.sv
`include "mask_unit_params.svh"

module mask_unit (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       uop_valid,
  input  mask_unit_pkg::rob_entry_t  rob_entry,
  input  mask_unit_pkg::funct3_t     funct3,
  input  mask_unit_pkg::funct6_t     funct6,
  input  mask_unit_pkg::vs1_op_t     vs1_opcode,
  input  logic                       vm,
  input  mask_unit_pkg::vl_t         vl,
  input  mask_unit_pkg::vl_t         vstart,
  input  mask_unit_pkg::uop_index_t  uop_index,
  input  mask_unit_pkg::eew_t        vd_eew,
  input  mask_unit_pkg::vreg_t       v0_data,
  input  mask_unit_pkg::vreg_t       vd_data,
  input  mask_unit_pkg::vreg_t       vs1_data,
  input  mask_unit_pkg::vreg_t       vs2_data,
  input  logic                       v0_valid,
  input  logic                       vd_valid,
  input  logic                       vs1_valid,
  input  logic                       vs2_valid,
  output logic                       result_valid,
  output mask_unit_pkg::rob_entry_t  result_rob_entry,
  output mask_unit_pkg::vreg_t       result_data,
  output logic                       ignore_vta,
  output logic                       ignore_vma
);

  logic                     issue;
  mask_unit_pkg::mask_op_t  op;
  mask_unit_pkg::vreg_t     logic_result;
  mask_unit_pkg::vreg_t     scan_result;
  mask_unit_pkg::vreg_t     index_result;

  mask_uop_decode u_decode (
    .uop_valid  (uop_valid),
    .funct3     (funct3),
    .funct6     (funct6),
    .vs1_opcode (vs1_opcode),
    .vm         (vm),
    .v0_valid   (v0_valid),
    .vd_valid   (vd_valid),
    .vs1_valid  (vs1_valid),
    .vs2_valid  (vs2_valid),
    .issue      (issue),
    .op         (op)
  );

  mask_logic_unit u_logic (
    .funct6       (funct6),
    .vstart       (vstart),
    .vs1_data     (vs1_data),
    .vs2_data     (vs2_data),
    .vd_data      (vd_data),
    .logic_result (logic_result)
  );

  mask_scan_unit u_scan (
    .op          (op),
    .vm          (vm),
    .vl          (vl),
    .v0_data     (v0_data),
    .vs2_data    (vs2_data),
    .vd_data     (vd_data),
    .scan_result (scan_result)
  );

  mask_index_unit u_index (
    .op           (op),
    .vm           (vm),
    .v0_data      (v0_data),
    .vs2_data     (vs2_data),
    .uop_index    (uop_index),
    .vd_eew       (vd_eew),
    .index_result (index_result)
  );

  // single output stage
  mask_result_reg u_result (
    .clk              (clk),
    .arst_n           (arst_n),
    .issue            (issue),
    .op               (op),
    .rob_entry        (rob_entry),
    .logic_result     (logic_result),
    .scan_result      (scan_result),
    .index_result     (index_result),
    .result_valid     (result_valid),
    .result_rob_entry (result_rob_entry),
    .result_data      (result_data),
    .ignore_vta       (ignore_vta),
    .ignore_vma       (ignore_vma)
  );

endmodule

//--- bench/tb_clock_gen.sv
module tb_clock_gen (
  output logic clk
);

  timeunit 1ns;
  timeprecision 100ps;

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

endmodule

//--- bench/mask_unit_tb.sv
`include "mask_unit_params.svh"

module mask_unit_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int UOPS_PER_TEST  = 40;
  localparam int TIMEOUT_CYCLES = 6 * UOPS_PER_TEST * 2 + 50;

  logic                       clk;
  logic                       arst_n;
  logic                       uop_valid;
  mask_unit_pkg::rob_entry_t  rob_entry;
  mask_unit_pkg::funct3_t     funct3;
  mask_unit_pkg::funct6_t     funct6;
  mask_unit_pkg::vs1_op_t     vs1_opcode;
  logic                       vm;
  mask_unit_pkg::vl_t         vl;
  mask_unit_pkg::vl_t         vstart;
  mask_unit_pkg::uop_index_t  uop_index;
  mask_unit_pkg::eew_t        vd_eew;
  mask_unit_pkg::vreg_t       v0_data;
  mask_unit_pkg::vreg_t       vd_data;
  mask_unit_pkg::vreg_t       vs1_data;
  mask_unit_pkg::vreg_t       vs2_data;
  logic                       v0_valid;
  logic                       vd_valid;
  logic                       vs1_valid;
  logic                       vs2_valid;
  logic                       result_valid;
  mask_unit_pkg::rob_entry_t  result_rob_entry;
  mask_unit_pkg::vreg_t       result_data;
  logic                       ignore_vta;
  logic                       ignore_vma;

  // expected outputs lag the inputs by one cycle
  logic                       exp_valid;
  logic                       exp_vta;
  logic                       exp_vma;
  mask_unit_pkg::rob_entry_t  exp_rob;
  mask_unit_pkg::vreg_t       exp_data;
  logic [3:0]                 cur_op;
  logic                       cur_issue;

  logic [31:0] lfsr;
  int          cycles;
  int          checks;
  int          errors;
  int          base_errors;
  int          tests_run;
  int          tests_failed;

  tb_clock_gen u_clock_gen (
    .clk (clk)
  );

  mask_unit u_mask_unit (
    .clk              (clk),
    .arst_n           (arst_n),
    .uop_valid        (uop_valid),
    .rob_entry        (rob_entry),
    .funct3           (funct3),
    .funct6           (funct6),
    .vs1_opcode       (vs1_opcode),
    .vm               (vm),
    .vl               (vl),
    .vstart           (vstart),
    .uop_index        (uop_index),
    .vd_eew           (vd_eew),
    .v0_data          (v0_data),
    .vd_data          (vd_data),
    .vs1_data         (vs1_data),
    .vs2_data         (vs2_data),
    .v0_valid         (v0_valid),
    .vd_valid         (vd_valid),
    .vs1_valid        (vs1_valid),
    .vs2_valid        (vs2_valid),
    .result_valid     (result_valid),
    .result_rob_entry (result_rob_entry),
    .result_data      (result_data),
    .ignore_vta       (ignore_vta),
    .ignore_vma       (ignore_vma)
  );

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output mask_unit_pkg::vreg_t v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[`VLEN-2:0], lfsr[0]};
    end
  endtask

  task automatic randomize_operands();
    mask_unit_pkg::vreg_t tmp;
    take_bits(`VLEN, v0_data);
    take_bits(`VLEN, vd_data);
    take_bits(`VLEN, vs1_data);
    take_bits(`VLEN, vs2_data);
    take_bits(8, tmp);
    vl = mask_unit_pkg::vl_t'(tmp % (`VLEN + 1));
    take_bits(7, tmp);
    vstart = mask_unit_pkg::vl_t'(tmp);
  endtask

  // valids packed as {v0, vd, vs1, vs2}
  task automatic drive_uop(input mask_unit_pkg::funct3_t f3, input mask_unit_pkg::funct6_t f6,
                           input mask_unit_pkg::vs1_op_t s1, input logic m,
                           input logic [3:0] valids);
    uop_valid  = 1'b1;
    rob_entry  = rob_entry + 1'b1;
    funct3     = f3;
    funct6     = f6;
    vs1_opcode = s1;
    vm         = m;
    {v0_valid, vd_valid, vs1_valid, vs2_valid} = valids;
  endtask

  // 4'hf marks an unsupported encoding
  function automatic logic [3:0] classify_uop();
    if (funct3 != `OPMVV) return 4'hf;
    if (funct6 >= `VMANDN && funct6 <= `VMXNOR) return `MOP_LOGIC;
    if (funct6 == `VWXUNARY0 && vs1_opcode == `VCPOP) return `MOP_CPOP;
    if (funct6 == `VWXUNARY0 && vs1_opcode == `VFIRST) return `MOP_FIRST;
    if (funct6 == `VMUNARY0) begin
      case (vs1_opcode)
        `VMSBF: return `MOP_SBF;
        `VMSIF: return `MOP_SIF;
        `VMSOF: return `MOP_SOF;
        `VIOTA: return `MOP_IOTA;
        `VID:   return `MOP_ID;
        default: return 4'hf;
      endcase
    end
    return 4'hf;
  endfunction

  function automatic logic accepts_uop(input logic [3:0] mop);
    logic unary_ok;
    unary_ok = !vs1_valid && vs2_valid && (vm || v0_valid);
    case (mop)
      `MOP_LOGIC: return uop_valid && vs1_valid && vs2_valid && vd_valid && vm;
      `MOP_CPOP, `MOP_FIRST, `MOP_IOTA: return uop_valid && unary_ok;
      `MOP_SBF, `MOP_SIF, `MOP_SOF: return uop_valid && unary_ok && (vm || vd_valid);
      `MOP_ID: return uop_valid;
      default: return 1'b0;
    endcase
  endfunction

  function automatic mask_unit_pkg::vreg_t expected_result(input logic [3:0] mop);
    mask_unit_pkg::vreg_t res;
    int   first;
    int   count;
    int   width;
    int   elems;
    int   g;
    int   value;
    logic a;
    logic b;
    res   = '0;
    first = -1;
    count = 0;
    for (int j = 0; j < `VLEN; j++) begin
      if (vs2_data[j] && j < vl && (vm || v0_data[j])) begin
        count++;
        if (first < 0) first = j;
      end
    end
    case (mop)
      `MOP_LOGIC: begin
        for (int j = 0; j < `VLEN; j++) begin
          a = vs2_data[j];
          b = vs1_data[j];
          case (funct6)
            `VMANDN: res[j] = a && !b;
            `VMAND:  res[j] = a && b;
            `VMOR:   res[j] = a || b;
            `VMXOR:  res[j] = a != b;
            `VMORN:  res[j] = a || !b;
            `VMNAND: res[j] = !(a && b);
            `VMNOR:  res[j] = !(a || b);
            default: res[j] = a == b;
          endcase
          if (j < vstart) res[j] = vd_data[j];
        end
      end
      `MOP_CPOP:  res = `VLEN'(count);
      `MOP_FIRST: res = (first < 0) ? {`VLEN{1'b1}} : `VLEN'(first);
      `MOP_SBF, `MOP_SIF, `MOP_SOF: begin
        for (int j = 0; j < `VLEN; j++) begin
          if (first < 0) res[j] = 1'b1;
          else if (mop == `MOP_SBF) res[j] = j < first;
          else if (mop == `MOP_SIF) res[j] = j <= first;
          else res[j] = j == first;
          if (!vm && j < vl && !v0_data[j]) res[j] = vd_data[j];
        end
      end
      `MOP_IOTA, `MOP_ID: begin
        width = 8 << vd_eew;
        elems = `VLEN / width;
        for (int e = 0; e < elems; e++) begin
          g     = uop_index * elems + e;
          count = 0;
          for (int j = 0; j < g; j++) begin
            if (vs2_data[j] && (vm || v0_data[j])) count++;
          end
          value = (mop == `MOP_ID) ? g : count;
          for (int k = 0; k < width; k++) res[e*width+k] = value[k];
        end
      end
      default: res = '0;
    endcase
    return res;
  endfunction

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      exp_valid <= 1'b0;
      exp_vta   <= 1'b0;
      exp_vma   <= 1'b0;
      exp_rob   <= '0;
      exp_data  <= '0;
    end else begin
      cur_op    = classify_uop();
      cur_issue = accepts_uop(cur_op);
      exp_valid <= cur_issue;
      exp_vma   <= cur_issue && (cur_op == `MOP_SBF || cur_op == `MOP_SIF || cur_op == `MOP_SOF);
      exp_vta   <= cur_issue && (cur_op == `MOP_LOGIC || cur_op == `MOP_SBF ||
                                 cur_op == `MOP_SIF || cur_op == `MOP_SOF);
      exp_rob   <= rob_entry;
      exp_data  <= expected_result(cur_op);
    end
  end

  task automatic value_error(input string name, input mask_unit_pkg::vreg_t got,
                             input mask_unit_pkg::vreg_t want);
    $display("ERROR %s: got %0h, expected %0h", name, got, want);
    errors++;
  endtask

  // outputs are stable on the falling edge
  always @(negedge clk) begin
    checks += exp_valid ? 5 : 3;
    assert (result_valid === exp_valid)
      else value_error("result_valid", `VLEN'(result_valid), `VLEN'(exp_valid));
    assert (ignore_vta === exp_vta)
      else value_error("ignore_vta", `VLEN'(ignore_vta), `VLEN'(exp_vta));
    assert (ignore_vma === exp_vma)
      else value_error("ignore_vma", `VLEN'(ignore_vma), `VLEN'(exp_vma));
    if (exp_valid) begin
      assert (result_rob_entry === exp_rob)
        else value_error("result_rob_entry", `VLEN'(result_rob_entry), `VLEN'(exp_rob));
      assert (result_data === exp_data)
        else value_error("result_data", result_data, exp_data);
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $finish;
    end
  end

  task automatic report_test(input string name);
    tests_run++;
    if (errors != base_errors) tests_failed++;
    $display("test %0d %s: %0d errors", tests_run, name, errors - base_errors);
    base_errors = errors;
  endtask

  // drain the last result before reporting
  task automatic finish_test(input string name);
    @(negedge clk);
    uop_valid = 1'b0;
    @(posedge clk);
    report_test(name);
  endtask

  task automatic logic_ops_test();
    for (int i = 0; i < UOPS_PER_TEST; i++) begin
      @(negedge clk);
      randomize_operands();
      drive_uop(`OPMVV, `VMANDN + 6'(i % 8), 5'd0, 1'b1, 4'b1111);
    end
    finish_test("mask logical");
  endtask

  task automatic count_first_test();
    for (int i = 0; i < UOPS_PER_TEST; i++) begin
      @(negedge clk);
      randomize_operands();
      if (i % 10 == 7) vs2_data = '0;
      drive_uop(`OPMVV, `VWXUNARY0, (i % 2) ? `VFIRST : `VCPOP, i[1], 4'b1101);
    end
    finish_test("vcpop and vfirst");
  endtask

  task automatic set_mask_test();
    mask_unit_pkg::vs1_op_t s1;
    for (int i = 0; i < UOPS_PER_TEST; i++) begin
      @(negedge clk);
      randomize_operands();
      if (i % 10 == 9) vs2_data = '0;
      case (i % 3)
        0:       s1 = `VMSBF;
        1:       s1 = `VMSIF;
        default: s1 = `VMSOF;
      endcase
      drive_uop(`OPMVV, `VMUNARY0, s1, i[1], 4'b1101);
    end
    finish_test("vmsbf vmsif vmsof");
  endtask

  // one register group per width and mask mode
  task automatic iota_test();
    for (int w = 0; w < 3; w++) begin
      for (int m = 0; m < 2; m++) begin
        for (int u = 0; u < 8; u++) begin
          @(negedge clk);
          if (u == 0) randomize_operands();
          vd_eew    = 2'(w);
          uop_index = 3'(u);
          drive_uop(`OPMVV, `VMUNARY0, `VIOTA, m[0], 4'b1101);
        end
      end
    end
    finish_test("viota");
  endtask

  task automatic vid_test();
    mask_unit_pkg::vreg_t r;
    for (int w = 0; w < 3; w++) begin
      for (int u = 0; u < 8; u++) begin
        @(negedge clk);
        randomize_operands();
        take_bits(5, r);
        vd_eew    = 2'(w);
        uop_index = 3'(u);
        drive_uop(`OPMVV, `VMUNARY0, `VID, r[4], r[3:0]);
      end
    end
    finish_test("vid");
  endtask

  task automatic reject_test();
    for (int i = 0; i < UOPS_PER_TEST; i++) begin
      @(negedge clk);
      randomize_operands();
      case (i % 8)
        0: drive_uop(3'b000, `VMAND, 5'd0, 1'b1, 4'b1111);
        1: drive_uop(`OPMVV, `VMOR, 5'd0, 1'b1, 4'b1110);
        2: drive_uop(`OPMVV, `VMXOR, 5'd0, 1'b0, 4'b1111);
        3: drive_uop(`OPMVV, `VWXUNARY0, `VCPOP, 1'b1, 4'b1111);
        4: drive_uop(`OPMVV, `VWXUNARY0, `VFIRST, 1'b0, 4'b0101);
        5: drive_uop(`OPMVV, `VMUNARY0, `VMSBF, 1'b0, 4'b1001);
        6: drive_uop(`OPMVV, `VMUNARY0, 5'b00111, 1'b1, 4'b1101);
        default: begin
          drive_uop(`OPMVV, `VMAND, 5'd0, 1'b1, 4'b1111);
          uop_valid = 1'b0;
        end
      endcase
    end
    finish_test("rejection");
  endtask

  initial begin
    lfsr       = 32'h4c5a;
    arst_n     = 1'b0;
    uop_valid  = 1'b0;
    rob_entry  = '0;
    funct3     = '0;
    funct6     = '0;
    vs1_opcode = '0;
    vm         = 1'b1;
    vl         = '0;
    vstart     = '0;
    uop_index  = '0;
    vd_eew     = `EEW8;
    v0_data    = '0;
    vd_data    = '0;
    vs1_data   = '0;
    vs2_data   = '0;
    {v0_valid, vd_valid, vs1_valid, vs2_valid} = 4'b0000;
    repeat (10) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    assert (result_valid === 1'b0 && ignore_vta === 1'b0 && ignore_vma === 1'b0 &&
            result_rob_entry === '0 && result_data === '0)
      else begin
        $display("outputs were not cleared by reset");
        errors++;
      end
    report_test("reset");
    logic_ops_test();
    count_first_test();
    set_mask_test();
    iota_test();
    vid_test();
    reject_test();
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+verilog
verilog/mask_unit_pkg.sv
verilog/mask_uop_decode.sv
verilog/mask_logic_unit.sv
verilog/mask_scan_unit.sv
verilog/mask_index_unit.sv
verilog/mask_result_reg.sv
verilog/mask_unit.sv
bench/tb_clock_gen.sv
bench/mask_unit_tb.sv
